// File: Makefile
TOP := pkt_fwd_tb
BIN := obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f pkt_fwd_top.f --top-module $(TOP)

# Output goes to the terminal, the grep sets the exit status
run: compile
	./$(BIN) +verilator+error+limit+1000 | tee /dev/stderr | \
		grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// File: hw/pkt_bank.sv
`timescale 1ns/1ps
`include "pkt_fwd_settings.svh"

module pkt_bank (
   input  logic                   clk,
   input  logic                   rst,
   input  pkt_data_pkg::bank_wr_t wr_i,
   input  logic                   mark_full_i,
   input  logic [`PKT_LEN_W-1:0]  len_i,
   input  logic                   clear_i,
   input  logic                   rd_en_i,
   input  logic [`PKT_ADDR_W-1:0] rd_addr_i,
   output logic [`PKT_DATA_W-1:0] rd_data_o,
   output logic                   rd_vld_o,
   output logic                   full_o,
   output logic [`PKT_LEN_W-1:0]  len_o
);

   localparam int DEPTH = 1 << `PKT_ADDR_W;

   // One packet worth of words
   logic [`PKT_DATA_W-1:0] mem_q [DEPTH];

   // Write port, registered read port and length register
   always_ff @(posedge clk) begin
      if (wr_i.en) begin
         mem_q[wr_i.addr] <= wr_i.data;
      end
      if (rd_en_i) begin
         rd_data_o <= mem_q[rd_addr_i];
      end
      if (mark_full_i) begin
         len_o <= len_i;
      end
   end

   // Full from the last capture write until the forwarder lets go
   always_ff @(posedge clk) begin
      if (rst) begin
         full_o <= 1'b0;
         rd_vld_o <= 1'b0;
      end else begin
         // Data is valid exactly one cycle after the read
         rd_vld_o <= rd_en_i;
         if (clear_i) begin
            full_o <= 1'b0;
         end else if (mark_full_i) begin
            full_o <= 1'b1;
         end
      end
   end

endmodule

// File: hw/pkt_capture.sv
`timescale 1ns/1ps
`include "pkt_fwd_settings.svh"

module pkt_capture (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         in_valid_i,
   input  pkt_data_pkg::in_word_t       in_word_i,
   input  logic [1:0]                   bank_full_i,
   output pkt_data_pkg::bank_wr_t [1:0] bank_wr_o,
   output logic [1:0]                   mark_full_o,
   output logic [`PKT_LEN_W-1:0]        len_o,
   output logic                         drop_o
);
   import pkt_ctrl_pkg::*;

   cap_state_e state_q;
   // Bank the next packet goes to, toggles per accepted packet
   logic sel_q;
   // Next word address and running byte count
   logic [`PKT_ADDR_W-1:0] addr_q;
   logic [`PKT_LEN_W-1:0] len_acc_q;
   // Registered write, one cycle behind the strobe
   logic [1:0] wr_en_q;
   logic [`PKT_ADDR_W-1:0] wr_addr_q;
   logic [`PKT_DATA_W-1:0] wr_data_q;

   logic start;
   logic accept;
   logic is_last;
   logic [`PKT_ADDR_W-1:0] cur_addr;
   logic [`PKT_LEN_W-1:0] cur_len;

   // Bytes carried by one word
   function automatic logic [`PKT_LEN_W-1:0] keep_bytes(input logic [`PKT_KEEP_W-1:0] keep);
      logic [`PKT_LEN_W-1:0] n;
      n = '0;
      for (int i = 0; i < `PKT_KEEP_W; i++) begin
         n = n + `PKT_LEN_W'(keep[i]);
      end
      return n;
   endfunction

   // First word of a packet
   assign start = in_valid_i && (state_q == CAP_IDLE);
   // Word goes into a bank, dropped packets never get here
   assign accept = (start && !bank_full_i[sel_q]) || (in_valid_i && (state_q == CAP_FILL));
   assign is_last = accept && in_word_i.last;

   // Restart address and length on the first word
   assign cur_addr = (state_q == CAP_IDLE) ? '0 : addr_q;
   assign cur_len = ((state_q == CAP_IDLE) ? '0 : len_acc_q) + keep_bytes(in_word_i.keep);

   // -------------------------------------------------------------------------
   // Control
   // -------------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= CAP_IDLE;
         sel_q <= 1'b0;
         wr_en_q <= 2'b00;
         mark_full_o <= 2'b00;
         drop_o <= 1'b0;
      end else begin
         // Drop is decided once, at the first word
         drop_o <= start && bank_full_i[sel_q];
         wr_en_q <= accept ? (sel_q ? 2'b10 : 2'b01) : 2'b00;
         mark_full_o <= is_last ? (sel_q ? 2'b10 : 2'b01) : 2'b00;
         if (is_last) begin
            sel_q <= ~sel_q;
         end
         case (state_q)
            CAP_IDLE: begin
               // Single-word packets stay in idle
               if (start && !in_word_i.last) begin
                  state_q <= bank_full_i[sel_q] ? CAP_DROP : CAP_FILL;
               end
            end
            CAP_FILL: begin
               if (is_last) begin
                  state_q <= CAP_IDLE;
               end
            end
            CAP_DROP: begin
               if (in_valid_i && in_word_i.last) begin
                  state_q <= CAP_IDLE;
               end
            end
            default: state_q <= CAP_IDLE;
         endcase
      end
   end

   // -------------------------------------------------------------------------
   // Payload
   // -------------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (accept) begin
         addr_q <= cur_addr + 1'b1;
         len_acc_q <= cur_len;
         wr_addr_q <= cur_addr;
         wr_data_q <= in_word_i.data;
      end
      // Length goes out with mark_full
      if (is_last) begin
         len_o <= cur_len;
      end
   end

   // Both banks see the same address and data, enable picks one
   always_comb begin
      for (int b = 0; b < 2; b++) begin
         bank_wr_o[b].en = wr_en_q[b];
         bank_wr_o[b].addr = wr_addr_q;
         bank_wr_o[b].data = wr_data_q;
      end
   end

endmodule

// File: hw/pkt_ctrl_pkg.sv
package pkt_ctrl_pkg;

   // Capture FSM
   typedef enum logic [1:0] {
      CAP_IDLE,   // Waiting for the first word of a packet
      CAP_FILL,   // Writing words into the target bank
      CAP_DROP    // Discarding words until the last one
   } cap_state_e;

   // Forwarder FSM
   typedef enum logic [1:0] {
      FWD_IDLE,   // No bank taken
      FWD_READ,   // Issuing reads to the current bank
      FWD_DRAIN   // All reads issued, waiting for the returns
   } fwd_state_e;

endpackage

// File: hw/pkt_data_pkg.sv
package pkt_data_pkg;

`include "pkt_fwd_settings.svh"

   // -------------------------------------------------------------------------
   // Ingress side
   // -------------------------------------------------------------------------

   // One word as it arrives from outside
   typedef struct packed {
      logic [`PKT_DATA_W-1:0] data;
      // All ones except on the last word
      logic [`PKT_KEEP_W-1:0] keep;
      logic                   last;
   } in_word_t;

   // One write into a packet bank
   typedef struct packed {
      logic                   en;
      logic [`PKT_ADDR_W-1:0] addr;
      logic [`PKT_DATA_W-1:0] data;
   } bank_wr_t;

   // -------------------------------------------------------------------------
   // Egress side
   // -------------------------------------------------------------------------

   // One AXI-Stream beat, TVALID travels separately
   typedef struct packed {
      logic [`PKT_DATA_W-1:0] tdata;
      logic [`PKT_KEEP_W-1:0] tkeep;
      logic                   tlast;
   } axis_beat_t;

endpackage

// File: hw/pkt_forwarder.sv
`timescale 1ns/1ps
`include "pkt_fwd_settings.svh"

module pkt_forwarder (
   input  logic                        clk,
   input  logic                        rst,
   input  logic [1:0]                  bank_full_i,
   input  logic [1:0][`PKT_LEN_W-1:0]  bank_len_i,
   output logic [1:0]                  rd_en_o,
   output logic [`PKT_ADDR_W-1:0]      rd_addr_o,
   input  logic [1:0][`PKT_DATA_W-1:0] rd_data_i,
   input  logic [1:0]                  rd_vld_i,
   output logic [1:0]                  clear_o,
   output pkt_data_pkg::axis_beat_t    beat_o,
   output logic                        tvalid_o,
   input  logic                        tready_i
);
   import pkt_data_pkg::*;
   import pkt_ctrl_pkg::*;

   localparam int QUEUE_D = 1 << `PKT_QUEUE_ORDER;
   localparam int CNT_W = `PKT_QUEUE_ORDER + 1;
   // Byte offset bits inside one word
   localparam int SHIFT = $clog2(`PKT_KEEP_W);

   // -------------------------------------------------------------------------
   // Signals
   // -------------------------------------------------------------------------

   axis_beat_t queue_mem [QUEUE_D];
   axis_beat_t ret_beat;
   logic [`PKT_QUEUE_ORDER-1:0] wr_ptr_q;
   logic [`PKT_QUEUE_ORDER-1:0] rd_ptr_q;
   // Filled plus reserved queue slots
   logic [CNT_W-1:0] in_flight_q;
   // Reserved slots whose read has not returned yet
   logic [CNT_W-1:0] pending_q;
   logic queue_full;
   logic rd_from_queue;
   logic wr_to_queue;

   fwd_state_e state_q;
   // Bank due to be served next, the other one is current
   logic nxt_q;
   logic cur_bank;
   logic rdy_for_fwd;
   logic rdy_for_fwd_ack;
   logic fwd_done;
   logic take;
   logic fwd_rd_en;
   // Last read of the packet issued this cycle
   logic last_i;
   // Word returning now is the last one
   logic last_ret_q;
   logic pending_zero_next;
   logic [`PKT_LEN_W-1:0] cur_len;
   logic [`PKT_LEN_W-1:0] len_m1;
   logic [`PKT_ADDR_W-1:0] max_addr;
   logic [`PKT_ADDR_W-1:0] addr_q;

   // Low-aligned mask for the final beat, a whole word when remainder is 0
   function automatic logic [`PKT_KEEP_W-1:0] tail_keep(input logic [`PKT_LEN_W-1:0] len);
      logic [SHIFT-1:0] rem;
      logic [`PKT_KEEP_W-1:0] mask;
      rem = len[SHIFT-1:0];
      mask = '1;
      if (rem != '0) begin
         mask = ~({`PKT_KEEP_W{1'b1}} << rem);
      end
      return mask;
   endfunction

   // -------------------------------------------------------------------------
   // Bank handshake
   // -------------------------------------------------------------------------

   assign cur_bank = ~nxt_q;
   assign rdy_for_fwd = bank_full_i[nxt_q];
   // Length stays put while the bank is full
   assign cur_len = bank_len_i[cur_bank];
   assign len_m1 = cur_len - 1'b1;
   assign max_addr = len_m1[`PKT_ADDR_W+SHIFT-1 -: `PKT_ADDR_W];

   assign pending_zero_next = (pending_q == CNT_W'(1)) && wr_to_queue && !fwd_rd_en;
   assign fwd_done = (state_q == FWD_DRAIN) && pending_zero_next;
   assign rdy_for_fwd_ack = (state_q == FWD_IDLE) || fwd_done;
   assign take = rdy_for_fwd && rdy_for_fwd_ack;
   assign clear_o = fwd_done ? (cur_bank ? 2'b10 : 2'b01) : 2'b00;

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= FWD_IDLE;
         nxt_q <= 1'b0;
      end else begin
         if (take) begin
            nxt_q <= ~nxt_q;
         end
         case (state_q)
            FWD_IDLE: state_q <= rdy_for_fwd ? FWD_READ : FWD_IDLE;
            FWD_READ: state_q <= last_i ? FWD_DRAIN : FWD_READ;
            FWD_DRAIN: begin
               // Go straight to the next bank when it is already waiting
               if (fwd_done) begin
                  state_q <= rdy_for_fwd ? FWD_READ : FWD_IDLE;
               end
            end
            default: state_q <= FWD_IDLE;
         endcase
      end
   end

   // -------------------------------------------------------------------------
   // Reads with reserved queue space
   // -------------------------------------------------------------------------

   // A pop in the same cycle frees a slot for this read
   assign queue_full = (in_flight_q == CNT_W'(QUEUE_D)) && !rd_from_queue;
   assign fwd_rd_en = (state_q == FWD_READ) && !queue_full;
   assign last_i = fwd_rd_en && (addr_q == max_addr);
   assign rd_en_o = fwd_rd_en ? (cur_bank ? 2'b10 : 2'b01) : 2'b00;
   assign rd_addr_o = addr_q;

   assign wr_to_queue = rd_vld_i[cur_bank];
   assign tvalid_o = (in_flight_q != pending_q);
   assign rd_from_queue = tvalid_o && tready_i;

   always_ff @(posedge clk) begin
      if (rst) begin
         in_flight_q <= '0;
         pending_q <= '0;
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         addr_q <= '0;
         last_ret_q <= 1'b0;
      end else begin
         in_flight_q <= in_flight_q + CNT_W'(fwd_rd_en) - CNT_W'(rd_from_queue);
         pending_q <= pending_q + CNT_W'(fwd_rd_en) - CNT_W'(wr_to_queue);
         wr_ptr_q <= wr_ptr_q + `PKT_QUEUE_ORDER'(wr_to_queue);
         rd_ptr_q <= rd_ptr_q + `PKT_QUEUE_ORDER'(rd_from_queue);
         // Wrap to zero after the last word of the packet
         addr_q <= last_i ? '0 : addr_q + `PKT_ADDR_W'(fwd_rd_en);
         last_ret_q <= last_i;
      end
   end

   // -------------------------------------------------------------------------
   // Output queue
   // -------------------------------------------------------------------------

   always_comb begin
      ret_beat.tdata = rd_data_i[cur_bank];
      ret_beat.tkeep = last_ret_q ? tail_keep(cur_len) : '1;
      ret_beat.tlast = last_ret_q;
   end

   always_ff @(posedge clk) begin
      if (wr_to_queue) begin
         queue_mem[wr_ptr_q] <= ret_beat;
      end
   end

   // Head of queue, steady until popped
   assign beat_o = queue_mem[rd_ptr_q];

endmodule

// File: hw/pkt_fwd_settings.svh
`ifndef PKT_FWD_SETTINGS_SVH
`define PKT_FWD_SETTINGS_SVH

// -------------------------------------------------------------------------
// Datapath widths
// -------------------------------------------------------------------------

// Stream word width in bits
`define PKT_DATA_W 64

// One byte enable per data byte
`define PKT_KEEP_W 8

// -------------------------------------------------------------------------
// Storage sizes
// -------------------------------------------------------------------------

// Word address inside one bank, 32 words or 256 bytes
`define PKT_ADDR_W 5

// Byte length of a stored packet
`define PKT_LEN_W 16

// Output queue holds 2**PKT_QUEUE_ORDER beats
`define PKT_QUEUE_ORDER 4

`endif

// File: hw/pkt_fwd_top.sv
`timescale 1ns/1ps
`include "pkt_fwd_settings.svh"

module pkt_fwd_top (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     in_valid_i,
   input  pkt_data_pkg::in_word_t   in_word_i,
   output logic                     drop_o,
   output pkt_data_pkg::axis_beat_t beat_o,
   output logic                     tvalid_o,
   input  logic                     tready_i
);
   import pkt_data_pkg::*;

   // Capture to banks
   bank_wr_t [1:0] bank_wr;
   logic [1:0] mark_full;
   logic [`PKT_LEN_W-1:0] cap_len;

   // Banks to forwarder
   logic [1:0] bank_full;
   logic [1:0][`PKT_LEN_W-1:0] bank_len;
   logic [1:0] rd_en;
   logic [`PKT_ADDR_W-1:0] rd_addr;
   logic [1:0][`PKT_DATA_W-1:0] rd_data;
   logic [1:0] rd_vld;
   logic [1:0] clear;

   pkt_capture u_capture (
      .clk         (clk),
      .rst         (rst),
      .in_valid_i  (in_valid_i),
      .in_word_i   (in_word_i),
      .bank_full_i (bank_full),
      .bank_wr_o   (bank_wr),
      .mark_full_o (mark_full),
      .len_o       (cap_len),
      .drop_o      (drop_o)
   );

   pkt_bank u_bank0 (
      .clk         (clk),
      .rst         (rst),
      .wr_i        (bank_wr[0]),
      .mark_full_i (mark_full[0]),
      .len_i       (cap_len),
      .clear_i     (clear[0]),
      .rd_en_i     (rd_en[0]),
      .rd_addr_i   (rd_addr),
      .rd_data_o   (rd_data[0]),
      .rd_vld_o    (rd_vld[0]),
      .full_o      (bank_full[0]),
      .len_o       (bank_len[0])
   );

   pkt_bank u_bank1 (
      .clk         (clk),
      .rst         (rst),
      .wr_i        (bank_wr[1]),
      .mark_full_i (mark_full[1]),
      .len_i       (cap_len),
      .clear_i     (clear[1]),
      .rd_en_i     (rd_en[1]),
      .rd_addr_i   (rd_addr),
      .rd_data_o   (rd_data[1]),
      .rd_vld_o    (rd_vld[1]),
      .full_o      (bank_full[1]),
      .len_o       (bank_len[1])
   );

   pkt_forwarder u_forwarder (
      .clk         (clk),
      .rst         (rst),
      .bank_full_i (bank_full),
      .bank_len_i  (bank_len),
      .rd_en_o     (rd_en),
      .rd_addr_o   (rd_addr),
      .rd_data_i   (rd_data),
      .rd_vld_i    (rd_vld),
      .clear_o     (clear),
      .beat_o      (beat_o),
      .tvalid_o    (tvalid_o),
      .tready_i    (tready_i)
   );

endmodule

// File: pkt_fwd_top.f
+incdir+hw
hw/pkt_data_pkg.sv
hw/pkt_ctrl_pkg.sv
hw/pkt_capture.sv
hw/pkt_bank.sv
hw/pkt_forwarder.sv
hw/pkt_fwd_top.sv
testbench/pkt_fwd_asserts.sv
testbench/pkt_fwd_tb.sv

// File: testbench/pkt_fwd_asserts.sv
`timescale 1ns/1ps

module pkt_fwd_asserts (
   input logic                     clk,
   input logic                     rst,
   input logic                     drop_i,
   input logic                     tvalid_i,
   input logic                     tready_i,
   input pkt_data_pkg::axis_beat_t beat_i,
   input logic [1:0]               mark_full_i,
   input logic [1:0]               bank_full_i,
   input logic [1:0]               clear_i
);

   // Failure count per property
   int err_reset = 0;
   int err_hold = 0;
   int err_spurious = 0;
   int err_mark = 0;
   int err_clear = 0;
   int fail_total;

   // Packets stored in a bank and packets fully sent out
   logic [15:0] pkts_in_q;
   logic [15:0] pkts_out_q;

   assign fail_total = err_reset + err_hold + err_spurious + err_mark + err_clear;

   always_ff @(posedge clk) begin
      if (rst) begin
         pkts_in_q <= '0;
         pkts_out_q <= '0;
      end else begin
         if (|mark_full_i) begin
            pkts_in_q <= pkts_in_q + 16'd1;
         end
         if (tvalid_i && tready_i && beat_i.tlast) begin
            pkts_out_q <= pkts_out_q + 16'd1;
         end
      end
   end

   // -------------------------------------------------------------------------
   // Stream protocol
   // -------------------------------------------------------------------------

   // Outputs quiet right after reset
   a_reset: assert property (@(posedge clk) rst |=> !tvalid_i && !drop_i)
      else begin
         $error("tvalid or drop high after reset");
         err_reset++;
      end

   // Held beat does not move
   a_hold: assert property (@(posedge clk) disable iff (rst)
      tvalid_i && !tready_i |=> tvalid_i && $stable(beat_i))
      else begin
         $error("beat changed while held");
         err_hold++;
      end

   // Some stored packet must still be unsent
   a_spurious: assert property (@(posedge clk) disable iff (rst)
      tvalid_i |-> pkts_in_q != pkts_out_q)
      else begin
         $error("tvalid without an accepted packet");
         err_spurious++;
      end

   // -------------------------------------------------------------------------
   // Bank control
   // -------------------------------------------------------------------------

   // Capture never overwrites a full bank
   a_mark: assert property (@(posedge clk) disable iff (rst)
      (mark_full_i & bank_full_i) == 2'b00)
      else begin
         $error("mark_full on a full bank");
         err_mark++;
      end

   // Forwarder only releases a bank it holds
   a_clear: assert property (@(posedge clk) disable iff (rst)
      (clear_i & ~bank_full_i) == 2'b00)
      else begin
         $error("clear on an empty bank");
         err_clear++;
      end

endmodule

// File: testbench/pkt_fwd_tb.sv
`timescale 1ns/1ps
`include "pkt_fwd_settings.svh"

module pkt_fwd_tb;
   import pkt_data_pkg::*;

   localparam int N_RAND = 12;
   localparam int N_FIXED = 6;
   localparam int FIXED_LENS [N_FIXED] = '{1, 8, 9, 256, 17, 255};
   localparam int N_PKTS = 2 * N_RAND + N_FIXED + 3;
   localparam int WATCHDOG_CYCLES = 40 * N_PKTS + 200;

   logic clk;
   logic rst;
   logic in_valid_i;
   in_word_t in_word_i;
   logic drop_o;
   axis_beat_t beat_o;
   logic tvalid_o;
   logic tready_i;

   // Expected beats in output order
   axis_beat_t exp_q[$];
   axis_beat_t exp_beat;
   int pkts_accepted = 0;
   int pkts_done = 0;
   int drop_cnt = 0;
   int beat_cnt = 0;
   int mon_errs = 0;
   int seq_errs = 0;
   // 0 holds tready low, 1 holds it high, 2 plays the random pattern
   int ready_mode = 0;
   logic ready_pat [1024];

   pkt_fwd_top u_dut (
      .clk        (clk),
      .rst        (rst),
      .in_valid_i (in_valid_i),
      .in_word_i  (in_word_i),
      .drop_o     (drop_o),
      .beat_o     (beat_o),
      .tvalid_o   (tvalid_o),
      .tready_i   (tready_i)
   );

   bind pkt_fwd_top pkt_fwd_asserts u_asserts (
      .clk         (clk),
      .rst         (rst),
      .drop_i      (drop_o),
      .tvalid_i    (tvalid_o),
      .tready_i    (tready_i),
      .beat_i      (beat_o),
      .mark_full_i (mark_full),
      .bank_full_i (bank_full),
      .clear_i     (clear)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // tready driver, changes only on the falling edge
   initial begin
      int cyc;
      cyc = 0;
      tready_i = 1'b0;
      forever begin
         @(negedge clk);
         cyc++;
         case (ready_mode)
            0: tready_i = 1'b0;
            1: tready_i = 1'b1;
            default: tready_i = ready_pat[cyc % 1024];
         endcase
      end
   end

   // -------------------------------------------------------------------------
   // Output monitor, compares each transfer with the model queue
   // -------------------------------------------------------------------------

   always @(posedge clk) begin
      if (!rst) begin
         if (drop_o) begin
            drop_cnt++;
         end
         if (tvalid_o && tready_i) begin
            if (exp_q.size() == 0) begin
               $display("ERROR at %0t: beat transferred with no packet expected", $time);
               mon_errs++;
            end else begin
               exp_beat = exp_q.pop_front();
               beat_cnt++;
               assert (beat_o.tdata == exp_beat.tdata) else begin
                  $display("CHECK FAILED at %0t: beat_o.tdata expected %h got %h",
                           $time, exp_beat.tdata, beat_o.tdata);
                  mon_errs++;
               end
               assert (beat_o.tkeep == exp_beat.tkeep) else begin
                  $display("CHECK FAILED at %0t: beat_o.tkeep expected %h got %h",
                           $time, exp_beat.tkeep, beat_o.tkeep);
                  mon_errs++;
               end
               assert (beat_o.tlast == exp_beat.tlast) else begin
                  $display("CHECK FAILED at %0t: beat_o.tlast expected %b got %b",
                           $time, exp_beat.tlast, beat_o.tlast);
                  mon_errs++;
               end
               if (exp_beat.tlast) begin
                  pkts_done++;
               end
            end
         end
      end
   end

   function automatic int total_errors();
      return seq_errs + mon_errs + u_dut.u_asserts.fail_total;
   endfunction

   // One packet of len bytes, called and returning on a falling edge
   task automatic send_packet(input int len, input bit expect_drop);
      int nwords;
      int rem;
      axis_beat_t beats[$];
      axis_beat_t b;
      nwords = (len + `PKT_KEEP_W - 1) / `PKT_KEEP_W;
      rem = len % `PKT_KEEP_W;
      for (int i = 0; i < nwords; i++) begin
         b.tdata = {$urandom, $urandom};
         b.tlast = (i == nwords - 1);
         // Low-aligned mask on a short final word
         b.tkeep = (b.tlast && rem != 0) ? ({`PKT_KEEP_W{1'b1}} >> (`PKT_KEEP_W - rem)) : '1;
         beats.push_back(b);
         in_valid_i = 1'b1;
         in_word_i.data = b.tdata;
         in_word_i.keep = b.tkeep;
         in_word_i.last = b.tlast;
         @(negedge clk);
      end
      in_valid_i = 1'b0;
      in_word_i = '0;
      if (!expect_drop) begin
         foreach (beats[i]) exp_q.push_back(beats[i]);
         pkts_accepted++;
      end
   endtask

   // At most one unsent packet ahead, so the target bank is always free
   task automatic paced_send(input int len);
      while (pkts_accepted - pkts_done > 1) @(negedge clk);
      send_packet(len, 1'b0);
   endtask

   task automatic wait_drain();
      while (pkts_accepted != pkts_done) @(negedge clk);
      repeat (4) @(negedge clk);
   endtask

   task automatic check_drops(input int start, input int n);
      assert (drop_cnt - start == n) else begin
         $display("CHECK FAILED at %0t: drop_o pulses expected %0d got %0d",
                  $time, n, drop_cnt - start);
         seq_errs++;
      end
   endtask

   task automatic report_test(input int num, input string name, input int errs_before);
      $display("test %0d %-18s packets=%0d beats=%0d errors=%0d",
               num, name, pkts_accepted, beat_cnt, total_errors() - errs_before);
   endtask

   // -------------------------------------------------------------------------
   // Test sequence
   // -------------------------------------------------------------------------

   initial begin
      int errs_start;
      int drops_start;
      void'($urandom(54));
      rst = 1'b1;
      in_valid_i = 1'b0;
      in_word_i = '0;
      // Roughly three cycles in four ready
      for (int i = 0; i < 1024; i++) begin
         ready_pat[i] = ($urandom % 4) != 0;
      end
      ready_mode = 1;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      repeat (2) @(negedge clk);

      // Random lengths, tready high
      errs_start = total_errors();
      drops_start = drop_cnt;
      for (int i = 0; i < N_RAND; i++) begin
         paced_send(1 + int'($urandom % 256));
      end
      wait_drain();
      check_drops(drops_start, 0);
      report_test(1, "random_lengths", errs_start);

      // Edge lengths for tkeep and tlast
      errs_start = total_errors();
      drops_start = drop_cnt;
      for (int i = 0; i < N_FIXED; i++) begin
         paced_send(FIXED_LENS[i]);
      end
      wait_drain();
      check_drops(drops_start, 0);
      report_test(2, "edge_lengths", errs_start);

      // Random back-pressure, hold checked by the bound assertions
      errs_start = total_errors();
      drops_start = drop_cnt;
      ready_mode = 2;
      for (int i = 0; i < N_RAND; i++) begin
         paced_send(1 + int'($urandom % 128));
      end
      wait_drain();
      check_drops(drops_start, 0);
      report_test(3, "random_tready", errs_start);

      // First packet outgrows the queue so both banks stay full for the third
      errs_start = total_errors();
      drops_start = drop_cnt;
      ready_mode = 0;
      repeat (2) @(negedge clk);
      send_packet(200, 1'b0);
      send_packet(1 + int'($urandom % 128), 1'b0);
      send_packet(1 + int'($urandom % 256), 1'b1);
      repeat (20) @(negedge clk);
      check_drops(drops_start, 1);
      ready_mode = 1;
      wait_drain();
      repeat (40) @(negedge clk);
      check_drops(drops_start, 1);
      report_test(4, "full_banks_drop", errs_start);

      $display("summary: packets=%0d beats=%0d drops=%0d errors=%0d",
               pkts_accepted, beat_cnt, drop_cnt, total_errors());
      if (total_errors() == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

   // Budget of 40 cycles per packet plus setup
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout: output did not drain within %0d cycles", WATCHDOG_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule
